// File: r5p_core.f
src/r5p_pkg.sv
src/r5p_idu.sv
src/r5p_gpr.sv
src/r5p_alu.sv
src/r5p_lsu.sv
src/r5p_wbu.sv
src/r5p_core.sv
testbench/r5p_core_tb.sv

// File: src/r5p_alu.sv
////////////////////
// RV32I ALU with address and link adders
// XLEN must be a power of two, shift amount is log2(XLEN) bits
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_alu
  import r5p_pkg::*;
#(
  int unsigned XLEN = 32  // register width
)(
  input  logic [6:0]      opc,   // major opcode
  input  logic [2:0]      fn3,   // funct3
  input  logic            alt,   // SUB/SRA select
  input  logic [XLEN-1:0] pc,    // instruction address
  input  logic [XLEN-1:0] rd1,   // source 1
  input  logic [XLEN-1:0] rd2,   // source 2
  input  logic [XLEN-1:0] imm,   // immediate
  output logic [XLEN-1:0] alu,   // result
  output logic [XLEN-1:0] pcs,   // link address
  output logic [XLEN-1:0] addr   // load/store/JALR address
);

  localparam int unsigned SHW = $clog2(XLEN);  // shift amount width

  logic        [XLEN-1:0] op2;  // second operand
  logic        [SHW-1:0]  sh;   // shift amount
  logic signed [XLEN-1:0] sra;  // arithmetic right shift

  assign op2 = (opc == OP) ? rd2 : imm;
  assign sh  = op2[SHW-1:0];
  assign sra = $signed(rd1) >>> sh;  // kept apart so it stays signed

  ////////////////////
  // Operation select
  ////////////////////
  always_comb begin
    if (opc == AUIPC) begin
      alu = pc + imm;
    end else if ((opc == OP) || (opc == OP_IMM)) begin
      case (fn3)
        // ADDI ignores alt, imm bit 10 lands there
        ADD_SUB: alu = (alt && (opc == OP)) ? rd1 - op2 : rd1 + op2;
        SLL:     alu = rd1 << sh;
        SLT:     alu = XLEN'($signed(rd1) < $signed(op2));
        SLTU:    alu = XLEN'(rd1 < op2);
        XOR:     alu = rd1 ^ op2;
        SRL_SRA: alu = alt ? sra : rd1 >> sh;
        OR:      alu = rd1 | op2;
        AND:     alu = rd1 & op2;
        default: alu = '0;
      endcase
    end else begin
      alu = '0;  // result not used
    end
  end

  assign pcs  = pc + XLEN'(4);  // return address for JAL/JALR
  assign addr = rd1 + imm;      // base plus offset

endmodule

`default_nettype wire

// File: src/r5p_core.sv
////////////////////
// Execute and write-back top, four-phase req/ack instruction port
// One instruction in flight, retire port valid one cycle
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_core
  import r5p_pkg::*;
#(
  int unsigned XLEN    = 32,  // register width
  int unsigned DMEM_AW = 8    // data memory word address width
)(
  input  logic            clk,
  input  logic            rst,
  input  logic            req,   // instruction request
  output logic            ack,   // instruction accepted
  input  logic [31:0]     insn,  // instruction word
  input  logic [XLEN-1:0] pc,    // instruction address
  output logic            wen,   // retire write enable
  output logic [4:0]      adr,   // retire destination
  output logic [XLEN-1:0] dat    // retire data
);

  // addi x0, x0, 0
  localparam logic [31:0] NOP = {12'd0, 5'd0, ADD_SUB, 5'd0, OP_IMM};

  logic            acc;   // acceptance this edge
  logic [1:0]      busy;  // cycles until retire
  insn_t           ir;    // instruction register
  logic [XLEN-1:0] pcr;   // PC register
  logic [6:0]      opc;
  logic [2:0]      fn3;
  logic            alt, we;
  logic [4:0]      rs1, rs2, rd;
  logic [XLEN-1:0] imm, lui, rd1, rd2, alu, pcs, addr, rdt;

  ////////////////////
  // Handshake
  ////////////////////
  assign acc = req & ~ack & (busy == 2'd0);

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ack  <= 1'b0;
      busy <= 2'd0;
    end else if (acc) begin
      ack  <= 1'b1;
      busy <= 2'd2;
    end else begin
      if (!req) ack <= 1'b0;           // return to zero phase
      if (busy != 2'd0) busy <= busy - 2'd1;
    end
  end

  // Back to NOP after one cycle so the instruction executes once
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ir <= NOP;
    end else if (acc) begin
      ir <= insn;
    end else if (busy == 2'd2) begin
      ir <= NOP;
    end
  end

  always_ff @(posedge clk) begin
    if (acc) pcr <= pc;
  end

  r5p_idu #(.XLEN(XLEN)) i_idu (
    .insn(ir), .opc(opc), .fn3(fn3), .alt(alt), .rs1(rs1), .rs2(rs2),
    .rd(rd), .we(we), .imm(imm), .lui(lui)
  );
  r5p_gpr #(.XLEN(XLEN)) i_gpr (
    .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2),
    .wen(wen), .adr(adr), .dat(dat)
  );
  r5p_alu #(.XLEN(XLEN)) i_alu (
    .opc(opc), .fn3(fn3), .alt(alt), .pc(pcr), .rd1(rd1), .rd2(rd2),
    .imm(imm), .alu(alu), .pcs(pcs), .addr(addr)
  );
  r5p_lsu #(.XLEN(XLEN), .DMEM_AW(DMEM_AW)) i_lsu (
    .clk(clk), .rst(rst), .opc(opc), .fn3(fn3), .addr(addr), .wdt(rd2),
    .rdt(rdt)
  );
  // Outputs double as the retire port
  r5p_wbu #(.XLEN(XLEN)) i_wbu (
    .clk(clk), .rst(rst), .opc(opc), .we(we), .rd(rd), .alu(alu),
    .lsu(rdt), .pcs(pcs), .lui(lui), .wen(wen), .adr(adr), .dat(dat)
  );

endmodule

`default_nettype wire

// File: src/r5p_gpr.sv
////////////////////
// 32 entry register file, asynchronous read
// x0 has no storage and always reads zero
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_gpr #(
  int unsigned XLEN = 32  // register width
)(
  input  logic            clk,
  input  logic            rst,
  input  logic [4:0]      rs1,  // read index 1
  input  logic [4:0]      rs2,  // read index 2
  output logic [XLEN-1:0] rd1,  // read data 1
  output logic [XLEN-1:0] rd2,  // read data 2
  input  logic            wen,  // write enable
  input  logic [4:0]      adr,  // write index
  input  logic [XLEN-1:0] dat   // write data
);

  logic [XLEN-1:0] gpr [1:31];  // x1 to x31

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      for (int r = 1; r < 32; r++) begin
        gpr[r] <= '0;
      end
    end else if (wen && (adr != 5'd0)) begin
      gpr[adr] <= dat;
    end
  end

  // Zero index never reaches the array
  assign rd1 = (rs1 == 5'd0) ? '0 : gpr[rs1];
  assign rd2 = (rs2 == 5'd0) ? '0 : gpr[rs2];

endmodule

`default_nettype wire

// File: src/r5p_idu.sv
////////////////////
// Instruction decoder, purely combinational
// Immediates are sign extended to XLEN, no illegal opcode detection
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_idu
  import r5p_pkg::*;
#(
  int unsigned XLEN = 32  // register width
)(
  input  insn_t            insn,  // instruction word
  output logic [6:0]       opc,   // major opcode
  output logic [2:0]       fn3,   // funct3
  output logic             alt,   // funct7 bit 5, SUB/SRA
  output logic [4:0]       rs1,   // source register 1
  output logic [4:0]       rs2,   // source register 2
  output logic [4:0]       rd,    // destination register
  output logic             we,    // rd write enable
  output logic [XLEN-1:0]  imm,   // operand immediate
  output logic [XLEN-1:0]  lui    // upper immediate
);

  logic we_op;  // opcode writes rd

  // Fields common to all formats
  assign opc = insn.r.opcode;
  assign fn3 = insn.r.funct3;
  assign alt = insn.r.funct7[5];
  assign rs1 = insn.r.rs1;
  assign rs2 = insn.r.rs2;
  assign rd  = insn.r.rd;

  // U immediate, low 12 bits zero
  assign lui = XLEN'($signed({insn.u.imm_31_12, 12'h000}));

  ////////////////////
  // Immediate select
  ////////////////////
  always_comb begin
    case (insn.r.opcode)
      OP_IMM,
      JALR,
      LOAD:    imm = XLEN'($signed(insn.i.imm_11_0));  // I format
      STORE:   imm = XLEN'($signed({insn.s.imm_11_5, insn.s.imm_4_0}));
      JAL: begin
        // J format, bit 0 implied zero
        imm = XLEN'($signed({insn.j.imm_20, insn.j.imm_19_12,
                             insn.j.imm_11, insn.j.imm_10_1, 1'b0}));
      end
      AUIPC,
      LUI:     imm = lui;  // added to PC by the ALU
      default: imm = '0;
    endcase
  end

  // Opcodes with a destination register
  always_comb begin
    case (insn.r.opcode)
      OP, OP_IMM, LUI, AUIPC,
      JAL, JALR, LOAD: we_op = 1'b1;
      BRANCH,
      STORE:           we_op = 1'b0;  // no rd field
      default:         we_op = 1'b0;
    endcase
  end

  // Writes to x0 dropped here
  assign we = we_op & (insn.r.rd != 5'd0);

endmodule

`default_nettype wire

// File: src/r5p_lsu.sv
////////////////////
// Load/store unit on a local word memory, read data one cycle late
// Misaligned addresses truncated, memory undefined until written
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_lsu
  import r5p_pkg::*;
#(
  int unsigned XLEN    = 32,  // word width
  int unsigned DMEM_AW = 8    // word address width
)(
  input  logic            clk,
  input  logic            rst,
  input  logic [6:0]      opc,   // major opcode
  input  logic [2:0]      fn3,   // access size
  input  logic [XLEN-1:0] addr,  // byte address
  input  logic [XLEN-1:0] wdt,   // store data
  output logic [XLEN-1:0] rdt    // aligned load data
);

  localparam int unsigned BN = XLEN / 8;      // bytes per word
  localparam int unsigned OW = $clog2(BN);    // byte offset width

  logic [XLEN-1:0]    mem [0:2**DMEM_AW-1];  // data memory
  logic [DMEM_AW-1:0] wad;                    // word address
  logic [OW-1:0]      ofs;                    // byte offset
  logic [BN-1:0]      ben;                    // byte enables
  logic [XLEN-1:0]    wsh;                    // store data in lanes
  logic [XLEN-1:0]    rdw;                    // read word
  logic [OW-1:0]      ofs_r;
  logic [2:0]         fn3_r;
  logic [XLEN-1:0]    rsh;                    // read word shifted down

  assign wad = addr[DMEM_AW+OW-1:OW];

  // Offset rounded down to the access size
  always_comb begin
    case (fn3)
      B, BU: begin ofs = addr[OW-1:0];          ben = BN'(1) << ofs; end
      H, HU: begin ofs = {addr[OW-1:1], 1'b0};  ben = BN'(3) << ofs; end
      default: begin ofs = '0;                  ben = '1;            end
    endcase
  end

  assign wsh = wdt << {ofs, 3'b000};

  ////////////////////
  // Memory
  ////////////////////
  always_ff @(posedge clk) begin
    if (opc == STORE) begin
      for (int b = 0; b < BN; b++) begin
        if (ben[b]) mem[wad][8*b+:8] <= wsh[8*b+:8];  // lane write
      end
    end
    rdw <= mem[wad];  // every cycle, old data on a store
  end

  // Access shape follows the read word
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      ofs_r <= '0;
      fn3_r <= W;
    end else begin
      ofs_r <= ofs;
      fn3_r <= fn3;
    end
  end

  // Align and extend
  assign rsh = rdw >> {ofs_r, 3'b000};
  always_comb begin
    case (fn3_r)
      B:       rdt = XLEN'($signed(rsh[7:0]));
      BU:      rdt = XLEN'(rsh[7:0]);
      H:       rdt = XLEN'($signed(rsh[15:0]));
      HU:      rdt = XLEN'(rsh[15:0]);
      default: rdt = rsh;  // word
    endcase
  end

endmodule

`default_nettype wire

// File: src/r5p_pkg.sv
////////////////////
// RV32I opcodes, funct3 codes and instruction format views
// Only the opcodes that the execute subsystem handles are listed
////////////////////
`default_nettype none

package r5p_pkg;

  // Major opcodes, insn[6:0]
  localparam logic [6:0] OP     = 7'b0110011;
  localparam logic [6:0] OP_IMM = 7'b0010011;
  localparam logic [6:0] LUI    = 7'b0110111;
  localparam logic [6:0] AUIPC  = 7'b0010111;
  localparam logic [6:0] JAL    = 7'b1101111;
  localparam logic [6:0] JALR   = 7'b1100111;
  localparam logic [6:0] LOAD   = 7'b0000011;
  localparam logic [6:0] STORE  = 7'b0100011;
  localparam logic [6:0] BRANCH = 7'b1100011;  // retires without write

  // ALU funct3
  localparam logic [2:0] ADD_SUB = 3'b000;
  localparam logic [2:0] SLL     = 3'b001;
  localparam logic [2:0] SLT     = 3'b010;
  localparam logic [2:0] SLTU    = 3'b011;
  localparam logic [2:0] XOR     = 3'b100;
  localparam logic [2:0] SRL_SRA = 3'b101;
  localparam logic [2:0] OR      = 3'b110;
  localparam logic [2:0] AND     = 3'b111;

  // Memory access size funct3
  localparam logic [2:0] B  = 3'b000;
  localparam logic [2:0] H  = 3'b001;
  localparam logic [2:0] W  = 3'b010;
  localparam logic [2:0] BU = 3'b100;
  localparam logic [2:0] HU = 3'b101;

  ////////////////////
  // Format views
  ////////////////////
  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
  } insn_r_t;
  typedef struct packed {
    logic [11:0] imm_11_0; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0]  rd;       logic [6:0] opcode;
  } insn_i_t;
  typedef struct packed {
    logic [6:0] imm_11_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3;   logic [4:0] imm_4_0; logic [6:0] opcode;
  } insn_s_t;
  typedef struct packed {
    logic [19:0] imm_31_12; logic [4:0] rd; logic [6:0] opcode;
  } insn_u_t;
  typedef struct packed {
    logic imm_20; logic [9:0] imm_10_1; logic imm_11;
    logic [7:0] imm_19_12; logic [4:0] rd; logic [6:0] opcode;
  } insn_j_t;

  // One word, five readings
  typedef union packed {
    insn_r_t r;
    insn_i_t i;
    insn_s_t s;
    insn_u_t u;
    insn_j_t j;
  } insn_t;

endpackage

`default_nettype wire

// File: src/r5p_wbu.sv
////////////////////
// Write-back unit, one register stage
// Load data bypasses the stage since the LSU already registered it
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_wbu
  import r5p_pkg::*;
#(
  int unsigned XLEN = 32  // register width
)(
  input  logic            clk,
  input  logic            rst,
  input  logic [6:0]      opc,  // opcode in execute
  input  logic            we,   // rd write enable
  input  logic [4:0]      rd,   // destination
  input  logic [XLEN-1:0] alu,  // ALU result
  input  logic [XLEN-1:0] lsu,  // aligned load data
  input  logic [XLEN-1:0] pcs,  // link address
  input  logic [XLEN-1:0] lui,  // upper immediate
  output logic            wen,  // GPR write enable
  output logic [4:0]      adr,  // GPR write index
  output logic [XLEN-1:0] dat   // GPR write data
);

  logic [6:0]      sel;  // registered opcode
  logic [XLEN-1:0] tmp;  // pre-selected result

  // Destination and select
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wen <= 1'b0;
      adr <= 5'd0;
      sel <= OP_IMM;
    end else begin
      wen <= we;
      adr <= rd;
      sel <= opc;
    end
  end

  ////////////////////
  // Pre-multiplexer
  ////////////////////
  always_ff @(posedge clk) begin
    case (opc)
      OP, OP_IMM, AUIPC: tmp <= alu;
      JAL, JALR:         tmp <= pcs;  // link
      LUI:               tmp <= lui;
      default:           tmp <= alu;  // loads take the bypass
    endcase
  end

  // Final select
  assign dat = (sel == LOAD) ? lsu : tmp;

endmodule

`default_nettype wire

// File: testbench/r5p_core_input.dat
# test insn pc wen rd data, all hex except the test name
# rd and data are ignored on lines with wen 0
addi_x1     00500093 00000100 1 01 00000005
addi_neg    FFD00113 00000104 1 02 FFFFFFFD
add         002081B3 00000108 1 03 00000002
sub         40208233 0000010C 1 04 00000008
slt         001122B3 00000110 1 05 00000001
sltu        00113333 00000114 1 06 00000000
slli        00409393 00000118 1 07 00000050
srai        40115413 0000011C 1 08 FFFFFFFE
xori        0FF3C513 00000120 1 0A 000000AF
andi        00F57613 00000124 1 0C 0000000F
lui         12345737 00000128 1 0E 12345000
auipc       00001797 0000012C 1 0F 0000112C
jal         0080086F 00000130 1 10 00000134
jalr        000088E7 00000138 1 11 0000013C
sw_40       04E02023 0000013C 0 00 00000000
sw_44       04402223 00000140 0 00 00000000
sb_45       042002A3 00000144 0 00 00000000
sh_46       04201323 00000148 0 00 00000000
lw_44       04402903 0000014C 1 12 FFFDFD08
lb_45       04500983 00000150 1 13 FFFFFFFD
lbu_45      04504A03 00000154 1 14 000000FD
lh_46       04601A83 00000158 1 15 FFFFFFFD
lhu_40      04005C03 0000015C 1 18 00005000
addi_x0     00708013 00000160 0 00 00000000
or_x0       00E06D33 00000164 1 1A 12345000
beq         00208463 00000168 0 00 00000000

// File: testbench/r5p_core_tb.sv
////////////////////
// Testbench for the execute and write-back core with vectors from a data file
// Run from the project root since the data file path is relative to it
////////////////////
`timescale 1ns/10ps
`default_nettype none

module r5p_core_tb;

  localparam int unsigned XLEN   = 32;
  localparam int          PERIOD = 40;  // ns

  logic            clk;
  logic            rst;
  logic            req;
  logic            ack;
  logic [31:0]     insn;
  logic [XLEN-1:0] pc;
  logic            wen;
  logic [4:0]      adr;
  logic [XLEN-1:0] dat;

  // Vector columns
  string       names [$];
  logic [31:0] insns [$];
  logic [31:0] pcs   [$];
  logic [31:0] wens  [$];
  logic [31:0] adrs  [$];
  logic [31:0] dats  [$];

  logic [31:0] rnd;         // LCG state
  int unsigned accepts;     // ack rising edges seen
  int unsigned retires;     // cycles with wen high
  int unsigned wen_expect;  // register writes so far
  logic        ack_q;       // ack at previous falling edge

  r5p_core #(.XLEN(XLEN), .DMEM_AW(8)) i_r5p_core (
    .clk(clk), .rst(rst), .req(req), .ack(ack), .insn(insn), .pc(pc),
    .wen(wen), .adr(adr), .dat(dat)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////
  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string test, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s %s: expected %h, actual %h", test, what, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    string       name;
    logic [31:0] f_insn, f_pc, f_wen, f_adr, f_dat;
    fd = $fopen("testbench/r5p_core_input.dat", "r");
    if (fd == 0) begin
      $display("Could not open testbench/r5p_core_input.dat");
      stop_with_failure();
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip blank and comment lines
        if ((line.len() > 1) && (line.getc(0) != "#")) begin
          n = $sscanf(line, "%s %h %h %h %h %h", name, f_insn, f_pc, f_wen, f_adr, f_dat);
          if (n != 6) begin
            $display("Malformed vector line: %s", line);
            stop_with_failure();
          end else begin
            names.push_back(name);
            insns.push_back(f_insn);
            pcs.push_back(f_pc);
            wens.push_back(f_wen);
            adrs.push_back(f_adr);
            dats.push_back(f_dat);
          end
        end
      end
      $fclose(fd);
    end
    if (names.size() == 0) begin
      $display("The data file holds no vectors");
      stop_with_failure();
    end
  endtask

  // One full four-phase transfer and its retire check
  task automatic run_vector(input int k);
    int unsigned gap;
    rnd = next_rand(rnd);
    gap = (rnd >> 16) & 32'd3;  // 0 to 3 idle cycles
    repeat (gap) @(posedge clk);
    @(posedge clk);
    req  <= 1'b1;
    insn <= insns[k];
    pc   <= pcs[k];
    // Ack seen mid cycle after acceptance
    @(negedge clk);
    while (!ack) @(negedge clk);
    @(negedge clk);  // second cycle after acceptance
    check_value(names[k], "ack", 32'd1, ack);
    check_value(names[k], "wen", wens[k], wen);
    if (wens[k][0]) begin
      check_value(names[k], "adr", adrs[k], adr);
      check_value(names[k], "dat", dats[k], dat);
      wen_expect++;
    end
    @(posedge clk);
    req <= 1'b0;
    // Return to zero phase
    @(negedge clk);
    while (ack) @(negedge clk);
    check_value(names[k], "accept count", k + 1, accepts);
    check_value(names[k], "write count", wen_expect, retires);
  endtask

  ////////////////////
  // Handshake monitor
  ////////////////////
  always @(negedge clk) begin
    if (!rst) begin
      if (ack && !ack_q) accepts++;
      if (ack_q && req) check_value("handshake", "ack held with req", 32'd1, ack);
      if (wen) retires++;  // one per writing instruction
      ack_q = ack;
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin
    rst        = 1'b1;
    req        = 1'b0;
    insn       = '0;
    pc         = '0;
    rnd        = 32'h64cb;
    accepts    = 0;
    retires    = 0;
    wen_expect = 0;
    ack_q      = 1'b0;
    load_vectors();
    // Watchdog allows ten cycles per vector plus margin
    fork
      begin
        #((names.size() * 10 + 50) * PERIOD);
        $display("Timeout: the req/ack handshake never completed");
        stop_with_failure();
      end
    join_none
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    for (int k = 0; k < names.size(); k++) begin
      run_vector(k);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
